/* trdb_cfg.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing of the trace encoder datapath and branch map
// include in any file that sizes ports or registers from these values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TRDB_CFG_SVH
`define TRDB_CFG_SVH

// instruction word and address width
`define TRDB_XLEN 32

// outcome bits held before a full-map packet
`define TRDB_BMAP_LEN 16

// branch count field, must hold TRDB_BMAP_LEN itself
`define TRDB_CNT_W 5

`endif

/* trdb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode decode constants and shared enums of the trace encoder
// import inside module bodies, use scoped names in port lists
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

package trdb_pkg;

    // conditional branches, rv32i
    localparam logic [`TRDB_XLEN-1:0] MASK_BEQ        = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_BEQ       = 32'h0000_0063;
    localparam logic [`TRDB_XLEN-1:0] MASK_BNE        = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_BNE       = 32'h0000_1063;
    localparam logic [`TRDB_XLEN-1:0] MASK_BLT        = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_BLT       = 32'h0000_4063;
    localparam logic [`TRDB_XLEN-1:0] MASK_BGE        = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_BGE       = 32'h0000_5063;
    localparam logic [`TRDB_XLEN-1:0] MASK_BLTU       = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_BLTU      = 32'h0000_6063;
    localparam logic [`TRDB_XLEN-1:0] MASK_BGEU       = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_BGEU      = 32'h0000_7063;

    // custom compare-with-immediate branches, funct3 slots 2 and 3
    localparam logic [`TRDB_XLEN-1:0] MASK_P_BEQIMM   = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_P_BEQIMM  = 32'h0000_2063;
    localparam logic [`TRDB_XLEN-1:0] MASK_P_BNEIMM   = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_P_BNEIMM  = 32'h0000_3063;

    // compressed branches, low halfword only
    localparam logic [`TRDB_XLEN-1:0] MASK_C_BEQZ     = 32'h0000_e003;
    localparam logic [`TRDB_XLEN-1:0] MATCH_C_BEQZ    = 32'h0000_c001;
    localparam logic [`TRDB_XLEN-1:0] MASK_C_BNEZ     = 32'h0000_e003;
    localparam logic [`TRDB_XLEN-1:0] MATCH_C_BNEZ    = 32'h0000_e001;

    // register-indirect jump
    localparam logic [`TRDB_XLEN-1:0] MASK_JALR       = 32'h0000_707f;
    localparam logic [`TRDB_XLEN-1:0] MATCH_JALR      = 32'h0000_0067;

    // packet formats, encodings follow the trace spec numbering
    typedef enum logic [1:0] {
        FMT_BRANCH_FULL = 2'b01,
        FMT_ADDR        = 2'b10,
        FMT_START       = 2'b11
    } pkt_format_e;

    // fill level of the tc/nc pair
    typedef enum logic [1:0] {
        ST_EMPTY = 2'b00,
        ST_ONE   = 2'b01,
        ST_PAIR  = 2'b10
    } stage_state_e;

endpackage

/* trdb_inst_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// staging of retired instructions into the tc/nc pair
// flags each new pair, or the very first instruction, with a one-cycle pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "trdb_cfg.svh"

module trdb_inst_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  inst_valid_i,
    input  logic [`TRDB_XLEN-1:0] inst_iaddr_i,
    input  logic [`TRDB_XLEN-1:0] inst_data_i,
    input  logic                  inst_compressed_i,
    input  logic                  inst_exception_i,
    output logic [`TRDB_XLEN-1:0] tc_iaddr_o,
    output logic                  tc_compressed_o,
    output logic [`TRDB_XLEN-1:0] nc_iaddr_o,
    output logic [`TRDB_XLEN-1:0] nc_data_o,
    output logic                  nc_exception_o,
    output logic                  pair_new_o,
    output logic                  first_new_o
);
    import trdb_pkg::*;

    stage_state_e state_q;
    stage_state_e state_d;
    logic         nc_compressed_q;

    // fill level only ever climbs until the next reset
    always_comb begin
        state_d = state_q;
        if (inst_valid_i) begin
            case (state_q)
                ST_EMPTY: state_d = ST_ONE;
                default:  state_d = ST_PAIR;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= ST_EMPTY;
            first_new_o <= 1'b0;
            pair_new_o  <= 1'b0;
        end else begin
            state_q     <= state_d;
            // a repeated address is still a new instruction
            first_new_o <= inst_valid_i && (state_q == ST_EMPTY);
            pair_new_o  <= inst_valid_i && (state_q != ST_EMPTY);
        end
    end

    // old nc becomes tc, new retirement lands in nc
    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            tc_iaddr_o      <= nc_iaddr_o;
            tc_compressed_o <= nc_compressed_q;
            nc_iaddr_o      <= inst_iaddr_i;
            nc_data_o       <= inst_data_i;
            nc_compressed_q <= inst_compressed_i;
            nc_exception_o  <= inst_exception_i;
        end
    end

    // core retires at most every other cycle
    a_strobe_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inst_valid_i |=> !inst_valid_i);

endmodule

/* trdb_itype_detector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction type detection on the tc/nc pair
// flags a conditional branch in tc, its outcome, and a discontinuity in nc
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "trdb_cfg.svh"

module trdb_itype_detector (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  inst_valid_i,
    input  logic [`TRDB_XLEN-1:0] nc_data_i,
    input  logic                  pair_new_i,
    input  logic [`TRDB_XLEN-1:0] tc_iaddr_i,
    input  logic                  tc_compressed_i,
    input  logic [`TRDB_XLEN-1:0] nc_iaddr_i,
    input  logic                  nc_exception_i,
    output logic                  tc_branch_o,
    output logic                  tc_branch_taken_o,
    output logic                  nc_updiscon_o
);
    import trdb_pkg::*;

    logic                  nc_is_branch;
    logic                  nc_is_jalr;
    logic [`TRDB_XLEN-1:0] tc_fall_addr;

    // any conditional branch, full size, custom or compressed
    assign nc_is_branch = ((nc_data_i & MASK_BEQ)      == MATCH_BEQ)      ||
                          ((nc_data_i & MASK_BNE)      == MATCH_BNE)      ||
                          ((nc_data_i & MASK_BLT)      == MATCH_BLT)      ||
                          ((nc_data_i & MASK_BGE)      == MATCH_BGE)      ||
                          ((nc_data_i & MASK_BLTU)     == MATCH_BLTU)     ||
                          ((nc_data_i & MASK_BGEU)     == MATCH_BGEU)     ||
                          ((nc_data_i & MASK_P_BEQIMM) == MATCH_P_BEQIMM) ||
                          ((nc_data_i & MASK_P_BNEIMM) == MATCH_P_BNEIMM) ||
                          ((nc_data_i & MASK_C_BEQZ)   == MATCH_C_BEQZ)   ||
                          ((nc_data_i & MASK_C_BNEZ)   == MATCH_C_BNEZ);

    // compressed jumps arrive already expanded
    assign nc_is_jalr = (nc_data_i & MASK_JALR) == MATCH_JALR;

    // sampled as nc shifts into tc, so it follows the new tc
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tc_branch_o <= 1'b0;
        end else if (inst_valid_i) begin
            tc_branch_o <= nc_is_branch;
        end
    end

    // fall-through of tc
    assign tc_fall_addr = tc_iaddr_i + (tc_compressed_i ? `TRDB_XLEN'd2 : `TRDB_XLEN'd4);

    // taken when nc is not the fall-through
    assign tc_branch_taken_o = pair_new_i && tc_branch_o && (nc_iaddr_i != tc_fall_addr);
    assign nc_updiscon_o     = pair_new_i && (nc_is_jalr || nc_exception_i);

    // taken needs a branch decoded on the strobe that formed this pair
    a_taken_on_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tc_branch_taken_o |-> $past(inst_valid_i && nc_is_branch));

endmodule

/* trdb_branch_map.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch map, packs one outcome bit per conditional branch
// cleared by the emitter's flush once the bits have gone out in a packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "trdb_cfg.svh"

module trdb_branch_map (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      pair_new_i,
    input  logic                      tc_branch_i,
    input  logic                      tc_branch_taken_i,
    input  logic                      flush_i,
    output logic [`TRDB_CNT_W-1:0]    bmap_count_o,
    output logic [`TRDB_BMAP_LEN-1:0] bmap_bits_o,
    output logic                      bmap_full_o
);

    localparam int IDX_W = $clog2(`TRDB_BMAP_LEN);
    localparam logic [`TRDB_CNT_W-1:0] FULL_CNT = `TRDB_CNT_W'(`TRDB_BMAP_LEN);

    logic record;
    logic outcome_bit;

    // one outcome per new pair whose tc is a branch
    assign record      = pair_new_i && tc_branch_i;
    // spec polarity, 1 is not taken
    assign outcome_bit = !tc_branch_taken_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bmap_count_o <= '0;
            bmap_bits_o  <= '0;
        end else if (flush_i) begin
            // fresh map, a coincident outcome opens it at bit 0
            bmap_count_o <= {{(`TRDB_CNT_W-1){1'b0}}, record};
            bmap_bits_o  <= {{(`TRDB_BMAP_LEN-1){1'b0}}, record && outcome_bit};
        end else if (record) begin
            bmap_bits_o[bmap_count_o[IDX_W-1:0]] <= outcome_bit;
            bmap_count_o <= bmap_count_o + 1'b1;
        end
    end

    assign bmap_full_o = (bmap_count_o == FULL_CNT);

    // emitter must drain the map before it overflows
    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bmap_count_o <= FULL_CNT);

endmodule

/* trdb_packet_emitter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet decision and output register of the trace encoder
// one packet per start, full map or uninferable discontinuity
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "trdb_cfg.svh"

module trdb_packet_emitter (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      first_new_i,
    input  logic                      pair_new_i,
    input  logic                      nc_updiscon_i,
    input  logic                      tc_branch_i,
    input  logic                      tc_branch_taken_i,
    input  logic [`TRDB_CNT_W-1:0]    bmap_count_i,
    input  logic [`TRDB_BMAP_LEN-1:0] bmap_bits_i,
    input  logic [`TRDB_XLEN-1:0]     nc_iaddr_i,
    output logic                      flush_o,
    output logic                      packet_valid_o,
    output trdb_pkg::pkt_format_e     packet_format_o,
    output logic [`TRDB_CNT_W-1:0]    packet_count_o,
    output logic [`TRDB_BMAP_LEN-1:0] packet_map_o,
    output logic [`TRDB_XLEN-1:0]     packet_addr_o
);
    import trdb_pkg::*;

    localparam int IDX_W = $clog2(`TRDB_BMAP_LEN);
    localparam logic [`TRDB_CNT_W-1:0] FULL_CNT = `TRDB_CNT_W'(`TRDB_BMAP_LEN);

    logic                      emit_d;
    pkt_format_e               fmt_d;
    logic [`TRDB_CNT_W-1:0]    eff_count;
    logic [`TRDB_BMAP_LEN-1:0] eff_map;

    // map as it will be once this pair's outcome is in
    always_comb begin
        eff_count = bmap_count_i;
        eff_map   = bmap_bits_i;
        if (pair_new_i && tc_branch_i) begin
            eff_map[bmap_count_i[IDX_W-1:0]] = !tc_branch_taken_i;
            eff_count = bmap_count_i + 1'b1;
        end
    end

    // discontinuity wins over a full map
    always_comb begin
        emit_d = 1'b1;
        fmt_d  = FMT_START;
        if (first_new_i) begin
            fmt_d = FMT_START;
        end else if (pair_new_i && nc_updiscon_i) begin
            fmt_d = FMT_ADDR;
        end else if (pair_new_i && (eff_count == FULL_CNT)) begin
            fmt_d = FMT_BRANCH_FULL;
        end else begin
            emit_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= emit_d;
        end
    end

    // start packet carries an empty map
    always_ff @(posedge clk_i) begin
        if (emit_d) begin
            packet_format_o <= fmt_d;
            packet_count_o  <= first_new_i ? '0 : eff_count;
            packet_map_o    <= first_new_i ? '0 : eff_map;
            packet_addr_o   <= nc_iaddr_i;
        end
    end

    // map clears after it has taken the outcome the packet reports
    assign flush_o = packet_valid_o;

    a_packet_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_o |=> !packet_valid_o);

endmodule

/* trdb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace encoder top level, fed by the core's retirement port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "trdb_cfg.svh"

module trdb_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      inst_valid_i,
    input  logic [`TRDB_XLEN-1:0]     inst_iaddr_i,
    input  logic [`TRDB_XLEN-1:0]     inst_data_i,
    input  logic                      inst_compressed_i,
    input  logic                      inst_exception_i,
    output logic                      packet_valid_o,
    output trdb_pkg::pkt_format_e     packet_format_o,
    output logic [`TRDB_CNT_W-1:0]    packet_count_o,
    output logic [`TRDB_BMAP_LEN-1:0] packet_map_o,
    output logic [`TRDB_XLEN-1:0]     packet_addr_o
);

    // pair staging
    logic [`TRDB_XLEN-1:0]     tc_iaddr;
    logic                      tc_compressed;
    logic [`TRDB_XLEN-1:0]     nc_iaddr;
    logic [`TRDB_XLEN-1:0]     nc_data;
    logic                      nc_exception;
    logic                      pair_new;
    logic                      first_new;
    // detector results
    logic                      tc_branch;
    logic                      tc_branch_taken;
    logic                      nc_updiscon;
    // branch map state
    logic [`TRDB_CNT_W-1:0]    bmap_count;
    logic [`TRDB_BMAP_LEN-1:0] bmap_bits;
    logic                      bmap_full;
    logic                      flush;

    trdb_inst_stage u_stage (
        .clk_i, .rst_ni, .inst_valid_i, .inst_iaddr_i, .inst_data_i,
        .inst_compressed_i, .inst_exception_i,
        .tc_iaddr_o(tc_iaddr), .tc_compressed_o(tc_compressed),
        .nc_iaddr_o(nc_iaddr), .nc_data_o(nc_data), .nc_exception_o(nc_exception),
        .pair_new_o(pair_new), .first_new_o(first_new)
    );

    trdb_itype_detector u_detector (
        .clk_i, .rst_ni, .inst_valid_i, .nc_data_i(nc_data), .pair_new_i(pair_new),
        .tc_iaddr_i(tc_iaddr), .tc_compressed_i(tc_compressed),
        .nc_iaddr_i(nc_iaddr), .nc_exception_i(nc_exception),
        .tc_branch_o(tc_branch), .tc_branch_taken_o(tc_branch_taken),
        .nc_updiscon_o(nc_updiscon)
    );

    trdb_branch_map u_bmap (
        .clk_i, .rst_ni, .pair_new_i(pair_new), .tc_branch_i(tc_branch),
        .tc_branch_taken_i(tc_branch_taken), .flush_i(flush),
        .bmap_count_o(bmap_count), .bmap_bits_o(bmap_bits), .bmap_full_o(bmap_full)
    );

    trdb_packet_emitter u_emitter (
        .clk_i, .rst_ni, .first_new_i(first_new), .pair_new_i(pair_new),
        .nc_updiscon_i(nc_updiscon), .tc_branch_i(tc_branch),
        .tc_branch_taken_i(tc_branch_taken), .bmap_count_i(bmap_count),
        .bmap_bits_i(bmap_bits), .nc_iaddr_i(nc_iaddr), .flush_o(flush),
        .packet_valid_o, .packet_format_o, .packet_count_o, .packet_map_o, .packet_addr_o
    );

    // a full map is only ever seen alongside the packet that drains it
    a_full_drained: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bmap_full |-> packet_valid_o);

endmodule

/* tb_trdb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of the trace encoder, replays trdb_cases.txt into the DUT
// and checks each emitted packet against the expected packets in that file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "trdb_cfg.svh"

module tb_trdb;
    import trdb_pkg::*;

    typedef struct packed {
        pkt_format_e           fmt;
        logic [`TRDB_XLEN-1:0] count;
        logic [`TRDB_XLEN-1:0] map;
        logic [`TRDB_XLEN-1:0] addr;
    } exp_pkt_t;

    // format names as they appear in the case file
    localparam logic [63:0] NAME_START = "START";
    localparam logic [63:0] NAME_FULL  = "FULL";
    localparam logic [63:0] NAME_ADDR  = "ADDR";

    logic                      clk_i;
    logic                      rst_ni;
    logic                      inst_valid_i;
    logic [`TRDB_XLEN-1:0]     inst_iaddr_i;
    logic [`TRDB_XLEN-1:0]     inst_data_i;
    logic                      inst_compressed_i;
    logic                      inst_exception_i;
    logic                      packet_valid_o;
    pkt_format_e               packet_format_o;
    logic [`TRDB_CNT_W-1:0]    packet_count_o;
    logic [`TRDB_BMAP_LEN-1:0] packet_map_o;
    logic [`TRDB_XLEN-1:0]     packet_addr_o;

    // retirements to drive, expected packets in arrival order
    logic [`TRDB_XLEN-1:0] stim_addr_q[$];
    logic [`TRDB_XLEN-1:0] stim_data_q[$];
    logic                  stim_comp_q[$];
    logic                  stim_exc_q[$];
    exp_pkt_t              exp_q[$];
    exp_pkt_t              cur_exp;

    int err_cnt     = 0;
    int pkt_cnt     = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 50;
    int n_rec       = 0;

    trdb_top uut (
        .clk_i, .rst_ni, .inst_valid_i, .inst_iaddr_i, .inst_data_i,
        .inst_compressed_i, .inst_exception_i,
        .packet_valid_o, .packet_format_o, .packet_count_o, .packet_map_o, .packet_addr_o
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic name_to_format(input logic [63:0] name, output pkt_format_e fmt);
        name_to_format = 1'b1;
        fmt = FMT_START;
        if (name == NAME_START) fmt = FMT_START;
        else if (name == NAME_FULL) fmt = FMT_BRANCH_FULL;
        else if (name == NAME_ADDR) fmt = FMT_ADDR;
        else name_to_format = 1'b0;
    endfunction

    // I lines become retirements, P lines expected packets
    function automatic logic load_cases();
        int                    fd;
        int                    code;
        int                    comp;
        int                    exc;
        logic                  done;
        logic [7:0]            tag;
        logic [63:0]           name;
        logic [8*128-1:0]      rest;
        logic [`TRDB_XLEN-1:0] a;
        logic [`TRDB_XLEN-1:0] d;
        logic [`TRDB_XLEN-1:0] m;
        exp_pkt_t              p;
        fd = $fopen("trdb_cases.txt", "r");
        if (fd == 0) return 1'b0;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %h %d %d", a, d, comp, exc);
                stim_addr_q.push_back(a);
                stim_data_q.push_back(d);
                stim_comp_q.push_back(comp != 0);
                stim_exc_q.push_back(exc != 0);
                n_rec++;
            end else if (tag == "P") begin
                code = $fscanf(fd, "%s %h %h %h", name, p.count, m, p.addr);
                p.map = m;
                if (!name_to_format(name, p.fmt)) begin
                    $display("unknown packet format in case file");
                    err_cnt++;
                end
                exp_q.push_back(p);
                n_rec++;
            end else begin
                $display("unknown record type in case file");
                err_cnt++;
                done = 1'b1;
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    task automatic check_format(input pkt_format_e exp, input pkt_format_e act);
        if (exp !== act) begin
            $display("FAIL packet_format_o expected %h got %h", exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_field(input string name, input logic [`TRDB_XLEN-1:0] exp,
                               input logic [`TRDB_XLEN-1:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // one strobe, then three idle cycles
    task automatic retire(input logic [`TRDB_XLEN-1:0] addr, input logic [`TRDB_XLEN-1:0] data,
                          input logic comp, input logic exc);
        @(negedge clk_i);
        inst_valid_i      = 1'b1;
        inst_iaddr_i      = addr;
        inst_data_i       = data;
        inst_compressed_i = comp;
        inst_exception_i  = exc;
        @(negedge clk_i);
        inst_valid_i      = 1'b0;
        inst_exception_i  = 1'b0;
        repeat (2) @(negedge clk_i);
    endtask

    // packet outputs are registered, stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_ni && packet_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("packet at address %h arrived with none expected", packet_addr_o);
                err_cnt++;
            end else begin
                cur_exp = exp_q.pop_front();
                check_format(cur_exp.fmt, packet_format_o);
                check_field("packet_count_o", cur_exp.count, `TRDB_XLEN'(packet_count_o));
                check_field("packet_map_o", cur_exp.map, `TRDB_XLEN'(packet_map_o));
                check_field("packet_addr_o", cur_exp.addr, packet_addr_o);
                pkt_cnt++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        rst_ni            = 1'b0;
        inst_valid_i      = 1'b0;
        inst_iaddr_i      = '0;
        inst_data_i       = '0;
        inst_compressed_i = 1'b0;
        inst_exception_i  = 1'b0;
        if (!load_cases()) begin
            $display("cannot open trdb_cases.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            cycle_limit = 4 * n_rec + 50;
            repeat (2) @(negedge clk_i);
            rst_ni = 1'b1;
            while (stim_addr_q.size() != 0) begin
                retire(stim_addr_q.pop_front(), stim_data_q.pop_front(),
                       stim_comp_q.pop_front(), stim_exc_q.pop_front());
            end
            repeat (4) @(negedge clk_i);
            if (exp_q.size() != 0) begin
                $display("%0d expected packets never arrived", exp_q.size());
                err_cnt += exp_q.size();
            end
            $display("packets checked %0d, errors %0d", pkt_cnt, err_cnt);
            if (err_cnt == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

/* trdb_cases.txt */
# I  address  word  compressed  exception   (one retired instruction, hex hex dec dec)
# P  format  count  map  address           (expected packet, format START FULL or ADDR)
I 00001000 00000013 0 0
P START 00 0000 00001000
I 00001004 00b50463 0 0
I 00001008 00b51463 0 0
I 00001100 00b54463 0 0
I 00001104 00b55463 0 0
I 00001200 00b56463 0 0
I 00001204 00b57463 0 0
I 00001208 00b52463 0 0
I 00001300 00b53463 0 0
I 00001304 0000c101 1 0
I 00001306 0000e101 1 0
I 00001400 00b50463 0 0
I 00001404 00000013 0 0
I 00001408 00b50463 0 0
I 0000140c 00b51463 0 0
I 00001500 00b50463 0 0
I 00001504 00b50463 0 0
I 00001508 00b50463 0 0
I 00001600 00000013 0 0
P FULL 10 6db5 00001600
# branch outcome and jalr in the same pair
I 00001604 00b50463 0 0
I 00001700 0000e101 1 0
I 00001702 00008067 0 0
P ADDR 02 0002 00001702
# exception after the map restarted
I 00002000 00b54463 0 0
I 00002004 00000013 0 1
P ADDR 01 0001 00002004

/* files.f */
+incdir+.
trdb_pkg.sv
trdb_inst_stage.sv
trdb_itype_detector.sv
trdb_branch_map.sv
trdb_packet_emitter.sv
trdb_top.sv
tb_trdb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall --timescale 1ns/1ps
TOP       = tb_trdb
FILELIST  = files.f
OBJDIR    = obj_dir
PASS_MSG  = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
